/* vlog.f */
+incdir+src
src/aluRsPkg.sv
src/firstOneSelect.sv
src/aluStation.sv
src/aluExecute.sv
src/aluCluster.sv
dv/aluClusterTb.sv

/* run.sh */
#!/bin/sh
# builds the ALU reservation-station testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f vlog.f --top-module aluClusterTb -Mdir "$OBJ" -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$OBJ/simv" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* dv/aluClusterTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "aluRs_defines.svh"

module aluClusterTb;

    localparam int RESET_CYCLES = 5;
    localparam int RANDOM_OPS   = 80;
    // each serial op needs about five cycles, directed phases stay under 150
    localparam int STIM_CYCLES  = RESET_CYCLES + 6 * RANDOM_OPS + 150;
    localparam int TIMEOUT_NS   = 4 * (STIM_CYCLES + 200);

    logic                clk;
    logic                rst;
    logic                dispatchEn;
    aluRsPkg::aluEntry_t dispatchEntry;
    aluRsPkg::cdbMsg_t   ldCdb;
    logic                free;
    aluRsPkg::cdbMsg_t   aluCdb;

    // expected value of every producer, indexed by tag
    logic [`DATA_WIDTH-1:0]   expData [2**`TAG_WIDTH];
    logic [2**`TAG_WIDTH-1:0] pending = '0;
    int                       dispatched = 0;
    int                       resultsSeen = 0;
    int                       resetEdges = 0;
    logic                     timedDispatch;
    logic                     expectFull;
    logic                     expectDrained;
    logic                     resultOk;
    logic [31:0]              lcgState = 32'h147f4f98;
    logic [`TAG_WIDTH-1:0]    nextTag = `TAG_FREE;

    aluCluster DUT (
        .clk          (clk),
        .rst          (rst),
        .dispatchEn   (dispatchEn),
        .dispatchEntry(dispatchEntry),
        .ldCdb        (ldCdb),
        .free         (free),
        .aluCdb       (aluCdb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic failAndStop(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    initial begin
        #(TIMEOUT_NS);
        failAndStop("timeout: the DUT stopped producing results");
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // tags cycle through 1..15, 0 stays reserved
    function automatic logic [`TAG_WIDTH-1:0] allocTag();
        nextTag = (nextTag == '1) ? `TAG_WIDTH'd1 : nextTag + `TAG_WIDTH'd1;
        return nextTag;
    endfunction

    function automatic logic [31:0] modelAlu(aluRsPkg::aluOp_e op, logic [31:0] a,
                                             logic [31:0] b);
        logic [4:0] s;
        s = b[4:0];
        case (op)
            aluRsPkg::ADD:  return a + b;
            aluRsPkg::SUB:  return a + ~b + 32'd1;
            aluRsPkg::SLL:  return a << s;
            // differing signs decide a signed compare on their own
            aluRsPkg::SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            aluRsPkg::SLTU: return {31'd0, a < b};
            aluRsPkg::XOR:  return a ^ b;
            aluRsPkg::SRL:  return a >> s;
            aluRsPkg::SRA:  return (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'd0);
            aluRsPkg::OR:   return a | b;
            aluRsPkg::AND:  return a & b;
            default:        return 32'd0;
        endcase
    endfunction

    assign resultOk = (aluCdb.data == expData[aluCdb.tag]);

    // scoreboard of tags in flight
    always @(posedge clk) begin
        if (rst) begin
            resetEdges <= resetEdges + 1;
        end else begin
            if (dispatchEn) begin
                pending[dispatchEntry.destTag] <= 1'b1;
                dispatched <= dispatched + 1;
            end
            if (aluCdb.valid) begin
                pending[aluCdb.tag] <= 1'b0;
                resultsSeen <= resultsSeen + 1;
            end
        end
    end

    assert property (@(posedge clk) (rst && resetEdges != 0) |-> !aluCdb.valid && free)
        else failAndStop($sformatf("FAIL %0t: result bus or full flag active in reset", $time));
    assert property (@(posedge clk) $fell(rst) |-> !aluCdb.valid && free)
        else failAndStop($sformatf("FAIL %0t: outputs not idle after reset", $time));
    assert property (@(posedge clk) disable iff (rst) aluCdb.valid |-> pending[aluCdb.tag])
        else failAndStop($sformatf("FAIL %0t: unexpected or repeated result for tag %0d",
                                   $time, $sampled(aluCdb.tag)));
    assert property (@(posedge clk) disable iff (rst) aluCdb.valid |-> resultOk)
        else failAndStop($sformatf("FAIL %0t: wrong data %h for tag %0d", $time,
                                   $sampled(aluCdb.data), $sampled(aluCdb.tag)));
    // both operands ready into an idle station, result two edges later
    assert property (@(posedge clk) disable iff (rst)
        $past(dispatchEn && timedDispatch, 2) |->
            aluCdb.valid && aluCdb.tag == $past(dispatchEntry.destTag, 2))
        else failAndStop($sformatf("FAIL %0t: result not two cycles after dispatch", $time));
    assert property (@(posedge clk) disable iff (rst) expectFull |-> !free)
        else failAndStop($sformatf("FAIL %0t: free high with every slot taken", $time));
    assert property (@(posedge clk) disable iff (rst) expectDrained |-> free)
        else failAndStop($sformatf("FAIL %0t: free low in an empty station", $time));

    task automatic stepCycle();
        @(negedge clk);
        dispatchEn = 1'b0;
        ldCdb.valid = 1'b0;
        timedDispatch = 1'b0;
    endtask

    task automatic waitDrained();
        while (pending != '0) begin
            @(negedge clk);
        end
        expectDrained = 1'b1;
    endtask

    // waiting operands carry junk data, the model uses the producer value
    task automatic dispatchOp(input aluRsPkg::aluOp_e op,
                              input logic [`TAG_WIDTH-1:0] tag1, input logic [31:0] val1,
                              input logic [`TAG_WIDTH-1:0] tag2, input logic [31:0] val2,
                              input logic [`TAG_WIDTH-1:0] dest);
        logic [31:0] a;
        logic [31:0] b;
        a = (tag1 == `TAG_FREE) ? val1 : expData[tag1];
        b = (tag2 == `TAG_FREE) ? val2 : expData[tag2];
        while (!free) begin
            @(negedge clk);
        end
        expData[dest] = modelAlu(op, a, b);
        expectDrained = 1'b0;
        dispatchEn = 1'b1;
        dispatchEntry = '{op: op, src1Tag: tag1, src1Data: val1, src2Tag: tag2,
                          src2Data: val2, destTag: dest};
    endtask

    task automatic driveLoad(input logic [`TAG_WIDTH-1:0] tag);
        ldCdb = '{valid: 1'b1, tag: tag, data: expData[tag]};
    endtask

    task automatic runTimed(input aluRsPkg::aluOp_e op, input logic [31:0] a,
                            input logic [31:0] b);
        dispatchOp(op, `TAG_FREE, a, `TAG_FREE, b, allocTag());
        timedDispatch = 1'b1;
        stepCycle();
        waitDrained();
    endtask

    initial begin
        logic [`TAG_WIDTH-1:0] tagA;
        logic [`TAG_WIDTH-1:0] tagB;
        logic [`TAG_WIDTH-1:0] loadTag;
        logic [`TAG_WIDTH-1:0] loadTags [`RS_SIZE];
        rst = 1'b1;
        dispatchEn = 1'b0;
        dispatchEntry = '0;
        ldCdb = '0;
        timedDispatch = 1'b0;
        expectFull = 1'b0;
        expectDrained = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        expectDrained = 1'b1;
        stepCycle();

        // signed versus unsigned compare, shift amount masking
        runTimed(aluRsPkg::SLT, 32'hffff_fff0, 32'd3);
        runTimed(aluRsPkg::SLTU, 32'hffff_fff0, 32'd3);
        runTimed(aluRsPkg::SRA, 32'h8000_0000, 32'h0000_0024);
        runTimed(aluRsPkg::SRL, 32'h8000_0000, 32'h0000_0024);
        runTimed(aluRsPkg::SLL, 32'h0000_0001, 32'hffff_ffe1);

        // chain, third op catches tagA by bypass on its dispatch edge
        tagA = allocTag();
        dispatchOp(aluRsPkg::ADD, `TAG_FREE, nextRandom(), `TAG_FREE, nextRandom(), tagA);
        stepCycle();
        tagB = allocTag();
        dispatchOp(aluRsPkg::SUB, tagA, nextRandom(), `TAG_FREE, nextRandom(), tagB);
        stepCycle();
        dispatchOp(aluRsPkg::XOR, tagB, nextRandom(), tagA, nextRandom(), allocTag());
        stepCycle();
        waitDrained();

        // load wakeup later, then on the dispatch edge itself
        loadTag = allocTag();
        expData[loadTag] = nextRandom();
        dispatchOp(aluRsPkg::OR, loadTag, nextRandom(), `TAG_FREE, 32'h00f0_0f00, allocTag());
        repeat (2) stepCycle();
        driveLoad(loadTag);
        stepCycle();
        loadTag = allocTag();
        expData[loadTag] = nextRandom();
        dispatchOp(aluRsPkg::AND, `TAG_FREE, 32'h0ff0_ffff, loadTag, nextRandom(), allocTag());
        driveLoad(loadTag);
        stepCycle();
        waitDrained();

        // fill every slot with ops waiting on loads
        for (int i = 0; i < `RS_SIZE; i++) begin
            loadTags[i] = allocTag();
            expData[loadTags[i]] = nextRandom();
            dispatchOp(aluRsPkg::aluOp_e'(4'(1 + i % 10)), loadTags[i], nextRandom(),
                       `TAG_FREE, nextRandom(), allocTag());
            stepCycle();
        end
        expectFull = 1'b1;
        repeat (3) stepCycle();
        expectFull = 1'b0;
        for (int i = 0; i < `RS_SIZE; i++) begin
            driveLoad(loadTags[i]);
            stepCycle();
        end
        waitDrained();

        for (int i = 0; i < RANDOM_OPS; i++) begin
            runTimed(aluRsPkg::aluOp_e'(4'(1 + i % 10)), nextRandom(), nextRandom());
        end
        stepCycle();

        if (resultsSeen == dispatched) begin
            $display("All tests passed");
            $finish;
        end else begin
            failAndStop($sformatf("%0d results seen for %0d dispatches", resultsSeen,
                                  dispatched));
        end
    end

endmodule

`default_nettype wire

/* src/aluCluster.sv */
`timescale 1ns/100ps
`default_nettype none

`include "aluRs_defines.svh"

module aluCluster (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatchEn,
    input  aluRsPkg::aluEntry_t dispatchEntry,
    input  aluRsPkg::cdbMsg_t   ldCdb,
    output logic                free,
    output aluRsPkg::cdbMsg_t   aluCdb
);

    logic                issueEn;
    aluRsPkg::aluEntry_t issueEntry;

    // station snoops its own result bus as the second wakeup source
    aluStation station (
        .clk          (clk),
        .rst          (rst),
        .dispatchEn   (dispatchEn),
        .dispatchEntry(dispatchEntry),
        .ldCdb        (ldCdb),
        .aluCdb       (aluCdb),
        .free         (free),
        .issueEn      (issueEn),
        .issueEntry   (issueEntry)
    );

    aluExecute execute (
        .clk       (clk),
        .rst       (rst),
        .issueEn   (issueEn),
        .issueEntry(issueEntry),
        .aluCdb    (aluCdb)
    );

endmodule

`default_nettype wire

/* src/aluExecute.sv */
`timescale 1ns/100ps
`default_nettype none

`include "aluRs_defines.svh"

module aluExecute (
    input  logic                clk,
    input  logic                rst,
    input  logic                issueEn,
    input  aluRsPkg::aluEntry_t issueEntry,
    output aluRsPkg::cdbMsg_t   aluCdb
);

    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] opB;
    logic [4:0]             shamt;
    logic [`DATA_WIDTH-1:0] result;
    logic                   validQ;
    logic [`TAG_WIDTH-1:0]  tagQ;
    logic [`DATA_WIDTH-1:0] dataQ;

    assign opA   = issueEntry.src1Data;
    assign opB   = issueEntry.src2Data;
    // RV32I shifts only look at the low five bits
    assign shamt = opB[4:0];

    always_comb begin
        case (issueEntry.op)
            aluRsPkg::ADD:  result = opA + opB;
            aluRsPkg::SUB:  result = opA - opB;
            aluRsPkg::SLL:  result = opA << shamt;
            aluRsPkg::SLT:  result = `DATA_WIDTH'($signed(opA) < $signed(opB));
            aluRsPkg::SLTU: result = `DATA_WIDTH'(opA < opB);
            aluRsPkg::XOR:  result = opA ^ opB;
            aluRsPkg::SRL:  result = opA >> shamt;
            aluRsPkg::SRA:  result = $unsigned($signed(opA) >>> shamt);
            aluRsPkg::OR:   result = opA | opB;
            aluRsPkg::AND:  result = opA & opB;
            default:        result = '0;
        endcase
    end

    // valid pulses once per issue
    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
        end else begin
            validQ <= issueEn;
        end
    end

    always_ff @(posedge clk) begin
        if (issueEn) begin
            tagQ  <= issueEntry.destTag;
            dataQ <= result;
        end
    end

    assign aluCdb = '{valid: validQ, tag: tagQ, data: dataQ};

    assert property (@(posedge clk) disable iff (rst) aluCdb.valid |-> aluCdb.tag != `TAG_FREE)
        else $error("alu result broadcast with free tag");

endmodule

`default_nettype wire

/* src/aluStation.sv */
`timescale 1ns/100ps
`default_nettype none

`include "aluRs_defines.svh"

module aluStation (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatchEn,
    input  aluRsPkg::aluEntry_t dispatchEntry,
    input  aluRsPkg::cdbMsg_t   ldCdb,
    input  aluRsPkg::cdbMsg_t   aluCdb,
    output logic                free,
    output logic                issueEn,
    output aluRsPkg::aluEntry_t issueEntry
);

    aluRsPkg::aluEntry_t rs [`RS_SIZE];

    logic [`RS_SIZE-1:0]      emptyVec;
    logic [`RS_SIZE-1:0]      readyVec;
    logic [`RS_SIZE-1:0]      freeGrant;
    logic [`RS_SIZE-1:0]      issueGrant;
    logic [`RS_IDX_WIDTH-1:0] issueIdx;
    logic                     freeFound;
    logic                     issueFound;

    // replace waiting tags with data from either result bus
    function automatic aluRsPkg::aluEntry_t snoop(
        input aluRsPkg::aluEntry_t e,
        input aluRsPkg::cdbMsg_t   busA,
        input aluRsPkg::cdbMsg_t   busB
    );
        aluRsPkg::aluEntry_t r;
        r = e;
        if (e.src1Tag != `TAG_FREE) begin
            if (busA.valid && busA.tag == e.src1Tag) begin
                r.src1Data = busA.data;
                r.src1Tag  = `TAG_FREE;
            end else if (busB.valid && busB.tag == e.src1Tag) begin
                r.src1Data = busB.data;
                r.src1Tag  = `TAG_FREE;
            end
        end
        if (e.src2Tag != `TAG_FREE) begin
            if (busA.valid && busA.tag == e.src2Tag) begin
                r.src2Data = busA.data;
                r.src2Tag  = `TAG_FREE;
            end else if (busB.valid && busB.tag == e.src2Tag) begin
                r.src2Data = busB.data;
                r.src2Tag  = `TAG_FREE;
            end
        end
        return r;
    endfunction

    // slot status straight from storage
    always_comb begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            emptyVec[i] = (rs[i].op == aluRsPkg::NOP);
            readyVec[i] = (rs[i].op != aluRsPkg::NOP) &&
                          (rs[i].src1Tag == `TAG_FREE) &&
                          (rs[i].src2Tag == `TAG_FREE);
        end
    end

    firstOneSelect #(
        .WIDTH(`RS_SIZE)
    ) freeSel (
        .req  (emptyVec),
        .grant(freeGrant),
        .index(),
        .found(freeFound)
    );

    firstOneSelect #(
        .WIDTH(`RS_SIZE)
    ) issueSel (
        .req  (readyVec),
        .grant(issueGrant),
        .index(issueIdx),
        .found(issueFound)
    );

    assign free       = freeFound;
    assign issueEn    = issueFound;
    assign issueEntry = rs[issueIdx];

    // issued slot empties, dispatch fills lowest empty slot, the rest snoop
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                rs[i].op <= aluRsPkg::NOP;
            end
        end else begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (issueGrant[i]) begin
                    rs[i].op <= aluRsPkg::NOP;
                end else if (dispatchEn && freeGrant[i]) begin
                    // bypass so a broadcast on the dispatch edge is not lost
                    rs[i] <= snoop(dispatchEntry, ldCdb, aluCdb);
                end else begin
                    rs[i] <= snoop(rs[i], ldCdb, aluCdb);
                end
            end
        end
    end

    // decoder must respect free
    assert property (@(posedge clk) disable iff (rst) dispatchEn |-> free)
        else $error("dispatch into a full station");

    assert property (@(posedge clk) disable iff (rst)
        dispatchEn |-> dispatchEntry.op != aluRsPkg::NOP)
        else $error("dispatched entry has op NOP");

    assert property (@(posedge clk) disable iff (rst)
        issueEn |-> (issueEntry.src1Tag == `TAG_FREE) && (issueEntry.src2Tag == `TAG_FREE))
        else $error("issued entry still waits on an operand");

endmodule

`default_nettype wire

/* src/firstOneSelect.sv */
`timescale 1ns/100ps
`default_nettype none

`include "aluRs_defines.svh"

module firstOneSelect #(
    parameter int WIDTH = `RS_SIZE
) (
    input  logic [WIDTH-1:0]         req,
    output logic [WIDTH-1:0]         grant,
    output logic [`RS_IDX_WIDTH-1:0] index,
    output logic                     found
);

    localparam int IDX_W = `RS_IDX_WIDTH;

    // two's complement keeps only the lowest set bit
    assign grant = req & (-req);
    assign found = |req;

    // grant is one-hot, so a plain scan encodes it
    always_comb begin
        index = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (grant[i]) begin
                index = IDX_W'(i);
            end
        end
    end

endmodule

`default_nettype wire

/* src/aluRsPkg.sv */
`default_nettype none

`include "aluRs_defines.svh"

package aluRsPkg;

    // NOP doubles as the empty slot marker
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        SLL  = 4'd3,
        SLT  = 4'd4,
        SLTU = 4'd5,
        XOR  = 4'd6,
        SRL  = 4'd7,
        SRA  = 4'd8,
        OR   = 4'd9,
        AND  = 4'd10
    } aluOp_e;

    // one station slot, operand tag of TAG_FREE means data is valid
    typedef struct packed {
        aluOp_e                  op;
        logic [`TAG_WIDTH-1:0]   src1Tag;
        logic [`DATA_WIDTH-1:0]  src1Data;
        logic [`TAG_WIDTH-1:0]   src2Tag;
        logic [`DATA_WIDTH-1:0]  src2Data;
        logic [`TAG_WIDTH-1:0]   destTag;
    } aluEntry_t;

    // result bus message, same layout for load and alu buses
    typedef struct packed {
        logic                    valid;
        logic [`TAG_WIDTH-1:0]   tag;
        logic [`DATA_WIDTH-1:0]  data;
    } cdbMsg_t;

endpackage

`default_nettype wire

/* src/aluRs_defines.svh */
`ifndef ALU_RS_DEFINES_SVH
`define ALU_RS_DEFINES_SVH

// operand and result width
`define DATA_WIDTH 32

// reorder buffer tag width
`define TAG_WIDTH 4

// tag 0 means the operand already holds its value
`define TAG_FREE `TAG_WIDTH'd0

// station depth, works from 2 to 16
`define RS_SIZE 4

// width of a station slot index
`define RS_IDX_WIDTH ($clog2(`RS_SIZE))

`endif
